//--- source/async_fifo_pkg.sv
`default_nettype none

package async_fifo_pkg;

    //////////////////////////////////////////////////////////////////////
    // FIFO sizing
    //////////////////////////////////////////////////////////////////////

    localparam int DATA_WIDTH    = 16;
    localparam int ADDRESS_WIDTH = 4;
    // All entries usable, the pointers carry one extra wrap bit
    localparam int DEPTH         = 1 << ADDRESS_WIDTH;

    // One stored word
    typedef logic [DATA_WIDTH-1:0] data_t;

    // Memory address, the low bits of a pointer
    typedef logic [ADDRESS_WIDTH-1:0] address_t;

    // Binary or Gray pointer with the wrap bit on top
    typedef logic [ADDRESS_WIDTH:0] pointer_t;

endpackage

`default_nettype wire

//--- source/fifo_memory_if.sv
`timescale 1ns/1ps
`default_nettype none

interface fifo_memory_if;
    import async_fifo_pkg::*;

    // Write port, owned by the write clock domain
    data_t    write_data;
    address_t write_address;
    logic     write_valid;

    // Read port, owned by the read clock domain
    address_t read_address;
    logic     read_enable;
    data_t    read_data;

    modport write_side (
        output write_data,
        output write_address,
        output write_valid
    );

    modport read_side (
        output read_address,
        output read_enable
    );

    modport memory (
        input  write_data,
        input  write_address,
        input  write_valid,
        input  read_address,
        input  read_enable,
        output read_data
    );

endinterface

`default_nettype wire

//--- source/fifo_write_controller.sv
`timescale 1ns/1ps
`default_nettype none

module fifo_write_controller (
    input  wire                      clock,
    input  wire                      reset_n,
    input  wire                      write_enable,
    input  wire async_fifo_pkg::data_t    write_data,
    input  wire async_fifo_pkg::pointer_t read_pointer_gray,
    output async_fifo_pkg::pointer_t write_pointer_gray,
    output logic                     full,
    fifo_memory_if.write_side        memory
);
    import async_fifo_pkg::*;

    pointer_t write_pointer;
    pointer_t next_write_pointer;
    pointer_t next_write_pointer_gray;
    pointer_t read_pointer_gray_sync_0;
    pointer_t read_pointer_gray_sync_1;
    pointer_t full_pattern;
    logic     write_accept;
    logic     next_full;

    //////////////////////////////////////////////////////////////////////
    // Next pointer and full flag
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        // Strobes are dropped while full
        write_accept            = write_enable && !full;
        next_write_pointer      = write_pointer + pointer_t'(write_accept);
        next_write_pointer_gray = next_write_pointer ^ (next_write_pointer >> 1);

        // Read pointer one lap behind, in Gray code
        full_pattern = {~read_pointer_gray_sync_1[ADDRESS_WIDTH:ADDRESS_WIDTH-1],
                        read_pointer_gray_sync_1[ADDRESS_WIDTH-2:0]};

        // Looking at the next pointer closes the one-cycle gap after a write
        next_full = (next_write_pointer_gray == full_pattern);
    end

    //////////////////////////////////////////////////////////////////////
    // Pointer, synchronizer and flag registers
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            write_pointer            <= '0;
            write_pointer_gray       <= '0;
            read_pointer_gray_sync_0 <= '0;
            read_pointer_gray_sync_1 <= '0;
            full                     <= 1'b0;
        end else begin
            write_pointer            <= next_write_pointer;
            // Registered so only one bit moves per crossing
            write_pointer_gray       <= next_write_pointer_gray;
            read_pointer_gray_sync_0 <= read_pointer_gray;
            read_pointer_gray_sync_1 <= read_pointer_gray_sync_0;
            full                     <= next_full;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Memory write port
    //////////////////////////////////////////////////////////////////////

    // Strobe toward memory, one cycle after acceptance
    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            memory.write_valid <= 1'b0;
        end else begin
            memory.write_valid <= write_accept;
        end
    end

    // Word and slot of the accepted write
    always_ff @(posedge clock) begin
        if (write_accept) begin
            memory.write_data    <= write_data;
            memory.write_address <= write_pointer[ADDRESS_WIDTH-1:0];
        end
    end

endmodule

`default_nettype wire

//--- source/fifo_read_controller.sv
`timescale 1ns/1ps
`default_nettype none

module fifo_read_controller (
    input  wire                      clock,
    input  wire                      reset_n,
    input  wire                      read_enable,
    input  wire async_fifo_pkg::pointer_t write_pointer_gray,
    output async_fifo_pkg::pointer_t read_pointer_gray,
    output logic                     empty,
    output logic                     read_data_valid,
    fifo_memory_if.read_side         memory
);
    import async_fifo_pkg::*;

    pointer_t read_pointer;
    pointer_t next_read_pointer;
    pointer_t next_read_pointer_gray;
    pointer_t write_pointer_gray_sync_0;
    pointer_t write_pointer_gray_sync_1;
    logic     read_accept;
    logic     next_empty;

    //////////////////////////////////////////////////////////////////////
    // Next pointer and empty flag
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        // Strobes are dropped while empty
        read_accept            = read_enable && !empty;
        next_read_pointer      = read_pointer + pointer_t'(read_accept);
        next_read_pointer_gray = next_read_pointer ^ (next_read_pointer >> 1);

        // Caught up with the writer, wrap bit included
        next_empty = (next_read_pointer_gray == write_pointer_gray_sync_1);
    end

    //////////////////////////////////////////////////////////////////////
    // Memory read port
    //////////////////////////////////////////////////////////////////////

    // Memory registers the word on the accepting edge
    always_comb begin
        memory.read_enable  = read_accept;
        memory.read_address = read_pointer[ADDRESS_WIDTH-1:0];
    end

    //////////////////////////////////////////////////////////////////////
    // Pointer, synchronizer and flag registers
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            read_pointer              <= '0;
            read_pointer_gray         <= '0;
            write_pointer_gray_sync_0 <= '0;
            write_pointer_gray_sync_1 <= '0;
            empty                     <= 1'b1;
        end else begin
            read_pointer              <= next_read_pointer;
            read_pointer_gray         <= next_read_pointer_gray;
            // Two stages before the Gray code is trusted
            write_pointer_gray_sync_0 <= write_pointer_gray;
            write_pointer_gray_sync_1 <= write_pointer_gray_sync_0;
            empty                     <= next_empty;
        end
    end

    // Valid lines up with read_data one cycle after acceptance
    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            read_data_valid <= 1'b0;
        end else begin
            read_data_valid <= read_accept;
        end
    end

endmodule

`default_nettype wire

//--- source/fifo_dual_port_memory.sv
`timescale 1ns/1ps
`default_nettype none

module fifo_dual_port_memory (
    input wire            write_clock,
    input wire            read_clock,
    fifo_memory_if.memory memory
);
    import async_fifo_pkg::*;

    // Storage array, contents undefined until written
    data_t storage [DEPTH];

    //////////////////////////////////////////////////////////////////////
    // Write port
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge write_clock) begin
        if (memory.write_valid) begin
            storage[memory.write_address] <= memory.write_data;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Read port
    //////////////////////////////////////////////////////////////////////

    // Synchronous read, held between accepted reads
    always_ff @(posedge read_clock) begin
        if (memory.read_enable) begin
            memory.read_data <= storage[memory.read_address];
        end
    end

endmodule

`default_nettype wire

//--- source/async_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module async_fifo (
    input  wire                           write_clock,
    input  wire                           read_clock,
    input  wire                           reset_n,

    // Write side
    input  wire                           write_enable,
    input  wire async_fifo_pkg::data_t    write_data,
    output logic                          full,

    // Read side
    input  wire                           read_enable,
    output async_fifo_pkg::data_t         read_data,
    output logic                          read_data_valid,
    output logic                          empty
);
    import async_fifo_pkg::*;

    // Gray pointers crossing between the two clock domains
    pointer_t write_pointer_gray;
    pointer_t read_pointer_gray;

    fifo_memory_if memory_bus ();

    //////////////////////////////////////////////////////////////////////
    // Write clock domain
    //////////////////////////////////////////////////////////////////////

    fifo_write_controller u_fifo_write_controller (
        .clock              (write_clock),
        .reset_n            (reset_n),
        .write_enable       (write_enable),
        .write_data         (write_data),
        .read_pointer_gray  (read_pointer_gray),
        .write_pointer_gray (write_pointer_gray),
        .full               (full),
        .memory             (memory_bus.write_side)
    );

    //////////////////////////////////////////////////////////////////////
    // Read clock domain
    //////////////////////////////////////////////////////////////////////

    fifo_read_controller u_fifo_read_controller (
        .clock              (read_clock),
        .reset_n            (reset_n),
        .read_enable        (read_enable),
        .write_pointer_gray (write_pointer_gray),
        .read_pointer_gray  (read_pointer_gray),
        .empty              (empty),
        .read_data_valid    (read_data_valid),
        .memory             (memory_bus.read_side)
    );

    //////////////////////////////////////////////////////////////////////
    // Storage shared by both domains
    //////////////////////////////////////////////////////////////////////

    fifo_dual_port_memory u_fifo_dual_port_memory (
        .write_clock (write_clock),
        .read_clock  (read_clock),
        .memory      (memory_bus.memory)
    );

    // Registered memory output goes straight out
    assign read_data = memory_bus.read_data;

endmodule

`default_nettype wire

//--- verif/async_fifo_checker.sv
`timescale 1ns/1ps
`default_nettype none

module async_fifo_checker (
    input  wire                        write_clock,
    input  wire                        read_clock,
    input  wire                        reset_n,
    input  wire                        write_enable,
    input  wire async_fifo_pkg::data_t write_data,
    input  wire                        full,
    input  wire async_fifo_pkg::data_t read_data,
    input  wire                        read_data_valid,
    output int                         error_count,
    output int                         model_count,
    output int                         compare_count
);
    import async_fifo_pkg::*;

    // Every accepted word in write order, read side walks it by index
    data_t model [$];
    int    push_count = 0;
    int    pop_count = 0;
    int    write_errors = 0;
    int    read_errors = 0;
    int    compared = 0;

    assign model_count   = push_count - pop_count;
    assign error_count   = write_errors + read_errors;
    assign compare_count = compared;

    // Oldest word not yet read back
    function automatic data_t expected_word();
        return model[pop_count];
    endfunction

    //////////////////////////////////////////////////////////////////////
    // Write side
    //////////////////////////////////////////////////////////////////////

    always @(posedge write_clock) begin
        if (reset_n && write_enable && !full) begin
            model.push_back(write_data);
            push_count = push_count + 1;
            if (push_count - pop_count > DEPTH) begin
                $display("Model holds %0d words at time %0t, more than the FIFO depth",
                         push_count - pop_count, $time);
                write_errors = write_errors + 1;
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Read side
    //////////////////////////////////////////////////////////////////////

    always @(posedge read_clock) begin
        data_t expected;
        if (reset_n && read_data_valid) begin
            if (pop_count >= push_count) begin
                $display("Read data came back at time %0t with nothing written", $time);
                read_errors = read_errors + 1;
            end else begin
                expected = expected_word();
                if (read_data !== expected) begin
                    $display("Fail at time %0t: read_data expected %h actual %h",
                             $time, expected, read_data);
                    read_errors = read_errors + 1;
                end
                pop_count = pop_count + 1;
                compared = compared + 1;
            end
        end
    end

endmodule

`default_nettype wire

//--- verif/async_fifo_tb.sv
`timescale 1ns/1ps
`default_nettype none

module async_fifo_tb;
    import async_fifo_pkg::*;

    localparam int WRITE_CYCLES  = 1500;
    localparam int READ_CYCLES   = 1000;
    localparam int WAIT_LIMIT    = 200;
    localparam int SETTLE_CYCLES = 4;

    logic        write_clock;
    logic        read_clock;
    logic        reset_n;
    logic        write_enable;
    logic        read_enable;
    data_t       write_data;
    data_t       read_data;
    logic        full;
    logic        empty;
    logic        read_data_valid;
    int          checker_errors;
    int          model_count;
    int          compare_count;
    int          tb_errors = 0;
    logic [31:0] rand_state = 32'h12ca_4df3;

    async_fifo u_async_fifo (
        .write_clock     (write_clock),
        .read_clock      (read_clock),
        .reset_n         (reset_n),
        .write_enable    (write_enable),
        .write_data      (write_data),
        .full            (full),
        .read_enable     (read_enable),
        .read_data       (read_data),
        .read_data_valid (read_data_valid),
        .empty           (empty)
    );

    async_fifo_checker u_async_fifo_checker (
        .write_clock     (write_clock),
        .read_clock      (read_clock),
        .reset_n         (reset_n),
        .write_enable    (write_enable),
        .write_data      (write_data),
        .full            (full),
        .read_data       (read_data),
        .read_data_valid (read_data_valid),
        .error_count     (checker_errors),
        .model_count     (model_count),
        .compare_count   (compare_count)
    );

    //////////////////////////////////////////////////////////////////////
    // Clocks, 4 ns write and 6 ns read
    //////////////////////////////////////////////////////////////////////

    initial begin
        write_clock = 1'b0;
        forever #2 write_clock = ~write_clock;
    end

    // Offset keeps read falling edges off the write edges
    initial begin
        read_clock = 1'b0;
        #1;
        forever #3 read_clock = ~read_clock;
    end

    function automatic logic [31:0] next_random();
        rand_state = rand_state * 32'd1664525 + 32'd1013904223;
        return rand_state;
    endfunction

    function automatic data_t known_word(input int index);
        return data_t'(index * 257) ^ 16'ha5c3;
    endfunction

    task automatic check_flag(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            $display("Fail at time %0t: %s expected %b actual %b",
                     $time, name, expected, actual);
            tb_errors++;
        end
    endtask

    task automatic check_count(input string name, input int expected, input int actual);
        if (actual != expected) begin
            $display("Fail at time %0t: %s expected %0d actual %0d",
                     $time, name, expected, actual);
            tb_errors++;
        end
    endtask

    task automatic wait_for_full(input logic level);
        int cycles;
        cycles = 0;
        while (full !== level && cycles < WAIT_LIMIT) begin
            @(negedge write_clock);
            cycles++;
        end
        if (full !== level) begin
            $display("Timeout: full did not reach %b within %0d write cycles", level, WAIT_LIMIT);
            tb_errors++;
        end
    endtask

    // Strobe reads until count words came back
    task automatic drain_words(input int count);
        int received;
        int cycles;
        received = 0;
        cycles = 0;
        while (received < count && cycles < WAIT_LIMIT) begin
            @(negedge read_clock);
            if (read_data_valid) begin
                received++;
            end
            read_enable = 1'b1;
            cycles++;
        end
        read_enable = 1'b0;
        // Checker takes the last word on the next rising edge
        @(negedge read_clock);
        if (received < count) begin
            $display("Timeout: only %0d of %0d words drained", received, count);
            tb_errors++;
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // Directed phases
    //////////////////////////////////////////////////////////////////////

    task automatic check_reset_state();
        @(negedge write_clock);
        check_flag("full", 1'b0, full);
        @(negedge read_clock);
        check_flag("empty", 1'b1, empty);
        check_flag("read_data_valid", 1'b0, read_data_valid);
        for (int i = 0; i < 4; i++) begin
            read_enable = 1'b1;
            @(negedge read_clock);
            check_flag("read_data_valid", 1'b0, read_data_valid);
        end
        read_enable = 1'b0;
        @(negedge read_clock);
        check_flag("read_data_valid", 1'b0, read_data_valid);
    endtask

    task automatic fill_until_full();
        for (int i = 0; i < DEPTH; i++) begin
            @(negedge write_clock);
            check_flag("full", 1'b0, full);
            write_enable = 1'b1;
            write_data = known_word(i);
        end
        @(negedge write_clock);
        check_flag("full", 1'b1, full);
        // Strobes while full must not land
        for (int i = 0; i < 4; i++) begin
            write_data = 16'hde00 | data_t'(i);
            @(negedge write_clock);
            check_flag("full", 1'b1, full);
        end
        write_enable = 1'b0;
        check_count("model_count", DEPTH, model_count);
    endtask

    task automatic check_idle_reads();
        check_flag("empty", 1'b1, empty);
        for (int i = 0; i < 4; i++) begin
            read_enable = 1'b1;
            @(negedge read_clock);
            check_flag("read_data_valid", 1'b0, read_data_valid);
            check_flag("empty", 1'b1, empty);
        end
        read_enable = 1'b0;
        check_count("model_count", 0, model_count);
    endtask

    //////////////////////////////////////////////////////////////////////
    // Random traffic, fill-heavy first half and drain-heavy second half
    //////////////////////////////////////////////////////////////////////

    task automatic random_writer();
        logic [31:0] r;
        for (int i = 0; i < WRITE_CYCLES; i++) begin
            @(negedge write_clock);
            r = next_random();
            write_data = r[31:16];
            write_enable = (i < WRITE_CYCLES / 2) ? (r[2:0] != 3'd0) : (r[2:0] < 3'd3);
            if (r[7:4] == 4'd0) begin
                write_enable = 1'b0;
                repeat (r[11:8]) @(negedge write_clock);
            end
        end
        @(negedge write_clock);
        write_enable = 1'b0;
    endtask

    task automatic random_reader();
        logic [31:0] r;
        for (int i = 0; i < READ_CYCLES; i++) begin
            @(negedge read_clock);
            r = next_random();
            read_enable = (i < READ_CYCLES / 2) ? (r[2:0] < 3'd3) : (r[2:0] != 3'd0);
            if (r[7:4] == 4'd0) begin
                read_enable = 1'b0;
                repeat (r[11:8]) @(negedge read_clock);
            end
        end
        @(negedge read_clock);
        read_enable = 1'b0;
    endtask

    // Both crossings quiet, flags must agree with the model for a few cycles in a row
    task automatic settle_flags();
        int cycles;
        int stable;
        cycles = 0;
        stable = 0;
        while (stable < SETTLE_CYCLES && cycles < WAIT_LIMIT) begin
            @(negedge read_clock);
            if ((full === (model_count == DEPTH)) && (empty === (model_count == 0))) begin
                stable++;
            end else begin
                stable = 0;
            end
            cycles++;
        end
        if (stable < SETTLE_CYCLES) begin
            $display("Timeout: full %b and empty %b never settled on the %0d words held",
                     full, empty, model_count);
            tb_errors++;
        end
    endtask

    initial begin
        write_enable = 1'b0;
        write_data = '0;
        read_enable = 1'b0;
        reset_n = 1'b0;
        repeat (5) @(negedge write_clock);
        reset_n = 1'b1;

        check_reset_state();
        fill_until_full();
        drain_words(DEPTH);
        check_idle_reads();
        wait_for_full(1'b0);

        fork
            random_writer();
            random_reader();
        join
        settle_flags();

        drain_words(model_count);
        check_flag("empty", 1'b1, empty);
        check_count("model_count", 0, model_count);

        $display("Checker errors %0d, testbench errors %0d, words compared %0d",
                 checker_errors, tb_errors, compare_count);
        if (checker_errors == 0 && tb_errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- all.f
source/async_fifo_pkg.sv
source/fifo_memory_if.sv
source/fifo_write_controller.sv
source/fifo_read_controller.sv
source/fifo_dual_port_memory.sv
source/async_fifo.sv
verif/async_fifo_checker.sv
verif/async_fifo_tb.sv

//--- run.sh
#!/bin/sh
# Compile and run the async FIFO testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing -j 0 \
    --top-module async_fifo_tb \
    -f all.f \
    -o async_fifo_sim

./obj_dir/async_fifo_sim > sim.log 2>&1
cat sim.log

if grep -q "ALL CHECKS PASSED" sim.log; then
    echo "Simulation passed"
else
    echo "Simulation failed"
    exit 1
fi
